// ==== common/axi_chan_pkg.sv ====
// AXI write channel field layout shared by the demultiplexer and its testbench.
// Only the AW, W and B channels are described; the read path is not used.
// No user, cache, prot, qos, region, lock or atop fields are carried.
// Strobe width follows the data width, one bit per byte.

package axi_chan_pkg;

  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [IdWidth-1:0]     id_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] strb_t;

  // AW beat, 49 bits
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } aw_chan_t;

  // W beat, 37 bits
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // B response, 6 bits
  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_chan_t;

endpackage

// ==== common/demux_pkg.sv ====
// Port select type and default configuration of the write demultiplexer.
// SelWidth limits the design to at most four master ports.
// The defaults are picked up by the top-level parameters.

package demux_pkg;

  localparam int unsigned SelWidth = 2;

  // Index of a master port
  typedef logic [SelWidth-1:0] sel_t;

  // ------------------
  // Defaults
  // ------------------
  // Number of master ports, 2 to 4
  localparam int unsigned DefNumMstPorts = 3;
  // Bursts in flight, also the depth of the W select FIFO
  localparam int unsigned DefMaxTrans    = 8;
  // Width of each per-ID outstanding counter
  localparam int unsigned DefCntWidth    = 4;
  // Low ID bits used to detect same-ID ordering hazards
  localparam int unsigned DefLookBits    = 2;

endpackage

// ==== hdl/id_tracker.sv ====
// Outstanding write counters, one per value of the low LookBits ID bits.
// Each counter also remembers the port of the last burst pushed with that ID.
// full_o rises as soon as any counter reaches its maximum value.
// A push and a pop of the same counter in one cycle cancel out.

`timescale 1ns/100ps

module id_tracker #(
  parameter int unsigned LookBits = demux_pkg::DefLookBits,
  parameter int unsigned CntWidth = demux_pkg::DefCntWidth
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [LookBits-1:0] lookup_id_i,
  output demux_pkg::sel_t     lookup_sel_o,
  output logic                lookup_busy_o,
  output logic                full_o,
  input  logic                push_i,
  input  logic [LookBits-1:0] push_id_i,
  input  demux_pkg::sel_t     push_sel_i,
  input  logic                pop_i,
  input  logic [LookBits-1:0] pop_id_i
);

  import demux_pkg::*;

  localparam int unsigned NumCnt = 2 ** LookBits;

  typedef logic [CntWidth-1:0] cnt_t;

  cnt_t              cnt_q [NumCnt];
  sel_t              sel_q [NumCnt];
  logic [NumCnt-1:0] cnt_full;

  // ------------------
  // Lookup
  // ------------------
  assign lookup_sel_o  = sel_q[lookup_id_i];
  assign lookup_busy_o = (cnt_q[lookup_id_i] != '0);
  assign full_o        = |cnt_full;

  // ------------------
  // Counters
  // ------------------
  for (genvar i = 0; i < NumCnt; i++) begin : gen_cnt
    logic push_en;
    logic pop_en;

    assign push_en     = push_i && (push_id_i == LookBits'(i));
    assign pop_en      = pop_i && (pop_id_i == LookBits'(i));
    assign cnt_full[i] = &cnt_q[i];

    always_ff @(posedge clk_i, negedge rst_ni) begin : proc_cnt
      if (!rst_ni) begin
        cnt_q[i] <= '0;
        sel_q[i] <= '0;
      end else begin
        if (push_en && !pop_en) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (pop_en && !push_en) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
        if (push_en) begin
          sel_q[i] <= push_sel_i;
        end
      end
    end
  end

  // A B for an ID with nothing outstanding means a bad response from a port
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (cnt_q[pop_id_i] != '0));

endmodule

// ==== hdl/sel_fifo.sv ====
// Register FIFO of port selects, one entry per burst still waiting for W data.
// Not fall-through: a pushed entry shows at data_o from the next cycle on.
// Depth may be any value from 1 up.

`timescale 1ns/100ps

module sel_fifo #(
  parameter int unsigned Depth = demux_pkg::DefMaxTrans
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            push_i,
  input  demux_pkg::sel_t data_i,
  input  logic            pop_i,
  output demux_pkg::sel_t data_o,
  output logic            full_o,
  output logic            empty_o
);

  import demux_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;

  sel_t                mem_q [Depth];
  ptr_t                wr_ptr_q;
  ptr_t                rd_ptr_q;
  logic [CntWidth-1:0] count_q;

  function automatic ptr_t ptr_next(ptr_t ptr);
    if (ptr == ptr_t'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin : proc_mem
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin : proc_ptr
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Push is gated by the AW side, pop by the W side
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

// ==== axi_write_demux/aw_issue.sv ====
// AW admission and routing, fully combinational.
// The AW payload goes to every port; only the selected port sees valid.
// An AW waits while the tracker or the select FIFO is full, or while its ID
// is outstanding on a different port.

`timescale 1ns/100ps

module aw_issue #(
  parameter int unsigned NumMstPorts = demux_pkg::DefNumMstPorts
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  axi_chan_pkg::aw_chan_t                   slv_aw_chan_i,
  input  demux_pkg::sel_t                          slv_aw_sel_i,
  input  logic                                     slv_aw_valid_i,
  output logic                                     slv_aw_ready_o,
  output axi_chan_pkg::aw_chan_t [NumMstPorts-1:0] mst_aw_chans_o,
  output logic [NumMstPorts-1:0]                   mst_aw_valids_o,
  input  logic [NumMstPorts-1:0]                   mst_aw_readies_i,
  input  demux_pkg::sel_t                          lookup_sel_i,
  input  logic                                     lookup_busy_i,
  input  logic                                     cnt_full_i,
  input  logic                                     fifo_full_i,
  output logic                                     aw_push_o
);

  import demux_pkg::*;

  logic [NumMstPorts-1:0] sel_onehot;
  logic                   admit;

  for (genvar i = 0; i < NumMstPorts; i++) begin : gen_port
    assign sel_onehot[i]     = (slv_aw_sel_i == sel_t'(i));
    assign mst_aw_chans_o[i] = slv_aw_chan_i;
  end

  // Same ID may only follow on the port it already uses
  assign admit = slv_aw_valid_i && !cnt_full_i && !fifo_full_i &&
                 (!lookup_busy_i || (lookup_sel_i == slv_aw_sel_i));

  assign mst_aw_valids_o = admit ? sel_onehot : '0;
  assign slv_aw_ready_o  = |(mst_aw_valids_o & mst_aw_readies_i);
  assign aw_push_o       = slv_aw_valid_i & slv_aw_ready_o;

  // --------------------
  // Assertions
  // --------------------
  a_sel_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_aw_valid_i |-> (slv_aw_sel_i < NumMstPorts));

  // Needs a stable slave AW and no tracker or FIFO change without a push
  a_admit_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (admit && !slv_aw_ready_o) |=> admit);

endmodule

// ==== axi_write_demux/w_steer.sv ====
// W beat steering. The head of the select FIFO names the port of the oldest
// burst still waiting for data. Nothing passes while the FIFO is empty.
// The head pops on the transfer of a beat with last set.

`timescale 1ns/100ps

module w_steer #(
  parameter int unsigned NumMstPorts = demux_pkg::DefNumMstPorts
) (
  input  axi_chan_pkg::w_chan_t                    slv_w_chan_i,
  input  logic                                     slv_w_valid_i,
  output logic                                     slv_w_ready_o,
  output axi_chan_pkg::w_chan_t [NumMstPorts-1:0]  mst_w_chans_o,
  output logic [NumMstPorts-1:0]                   mst_w_valids_o,
  input  logic [NumMstPorts-1:0]                   mst_w_readies_i,
  input  logic                                     empty_i,
  input  demux_pkg::sel_t                          head_sel_i,
  output logic                                     pop_o
);

  import demux_pkg::*;

  logic [NumMstPorts-1:0] head_onehot;

  for (genvar i = 0; i < NumMstPorts; i++) begin : gen_port
    assign head_onehot[i]   = !empty_i && (head_sel_i == sel_t'(i));
    assign mst_w_chans_o[i] = slv_w_chan_i;
  end

  assign mst_w_valids_o = slv_w_valid_i ? head_onehot : '0;
  assign slv_w_ready_o  = |(head_onehot & mst_w_readies_i);
  assign pop_o          = slv_w_valid_i & slv_w_ready_o & slv_w_chan_i.last;

endmodule

// ==== axi_write_demux/b_arbiter.sv ====
// Round-robin arbiter for the B responses of the master ports.
// The grant is held while the slave side stalls, so the B payload stays put.
// After each transfer the priority moves to the port after the winner.

`timescale 1ns/100ps

module b_arbiter #(
  parameter int unsigned NumMstPorts = demux_pkg::DefNumMstPorts
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  axi_chan_pkg::b_chan_t [NumMstPorts-1:0]  mst_b_chans_i,
  input  logic [NumMstPorts-1:0]                   mst_b_valids_i,
  output logic [NumMstPorts-1:0]                   mst_b_readies_o,
  output axi_chan_pkg::b_chan_t                    slv_b_chan_o,
  output logic                                     slv_b_valid_o,
  input  logic                                     slv_b_ready_i
);

  import demux_pkg::*;

  sel_t prio_q;
  sel_t lock_idx_q;
  logic lock_q;
  sel_t rr_idx;
  sel_t gnt_idx;
  logic any_req;

  // First requester at or after the priority pointer
  always_comb begin : proc_rr_pick
    int unsigned cand;
    rr_idx  = prio_q;
    any_req = 1'b0;
    for (int unsigned k = 0; k < NumMstPorts; k++) begin
      cand = prio_q + k;
      if (cand >= NumMstPorts) begin
        cand = cand - NumMstPorts;
      end
      if (!any_req && mst_b_valids_i[cand]) begin
        any_req = 1'b1;
        rr_idx  = sel_t'(cand);
      end
    end
  end

  assign gnt_idx       = lock_q ? lock_idx_q : rr_idx;
  assign slv_b_valid_o = lock_q ? mst_b_valids_i[lock_idx_q] : any_req;
  assign slv_b_chan_o  = mst_b_chans_i[gnt_idx];

  for (genvar i = 0; i < NumMstPorts; i++) begin : gen_ready
    assign mst_b_readies_o[i] = slv_b_valid_o && slv_b_ready_i && (gnt_idx == sel_t'(i));
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin : proc_state
    if (!rst_ni) begin
      prio_q     <= '0;
      lock_idx_q <= '0;
      lock_q     <= 1'b0;
    end else begin
      lock_q     <= slv_b_valid_o && !slv_b_ready_i;
      lock_idx_q <= gnt_idx;
      if (slv_b_valid_o && slv_b_ready_i) begin
        prio_q <= (gnt_idx == sel_t'(NumMstPorts - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  // Holds only if the granted master keeps its B stable until accepted
  a_b_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_b_valid_o && !slv_b_ready_i) |=> (slv_b_valid_o && $stable(slv_b_chan_o)));

endmodule

// ==== axi_write_demux/axi_write_demux.sv ====
// Write-path demultiplexer: one slave AW/W/B port to NumMstPorts master ports.
// slv_aw_sel_i must be below NumMstPorts and stable while slv_aw_valid_i is high.
// W beats must come in AW order; the first beat may go the cycle after its AW.
// An AW is held while its low LookBits ID bits are outstanding on another port.
// LookBits must not exceed the AXI ID width. No read path is provided.

`timescale 1ns/100ps

module axi_write_demux #(
  parameter int unsigned NumMstPorts = demux_pkg::DefNumMstPorts,
  parameter int unsigned MaxTrans    = demux_pkg::DefMaxTrans,
  parameter int unsigned CntWidth    = demux_pkg::DefCntWidth,
  parameter int unsigned LookBits    = demux_pkg::DefLookBits
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Slave port
  input  axi_chan_pkg::aw_chan_t                   slv_aw_chan_i,
  input  demux_pkg::sel_t                          slv_aw_sel_i,
  input  logic                                     slv_aw_valid_i,
  output logic                                     slv_aw_ready_o,
  input  axi_chan_pkg::w_chan_t                    slv_w_chan_i,
  input  logic                                     slv_w_valid_i,
  output logic                                     slv_w_ready_o,
  output axi_chan_pkg::b_chan_t                    slv_b_chan_o,
  output logic                                     slv_b_valid_o,
  input  logic                                     slv_b_ready_i,
  // Master ports
  output axi_chan_pkg::aw_chan_t [NumMstPorts-1:0] mst_aw_chans_o,
  output logic [NumMstPorts-1:0]                   mst_aw_valids_o,
  input  logic [NumMstPorts-1:0]                   mst_aw_readies_i,
  output axi_chan_pkg::w_chan_t [NumMstPorts-1:0]  mst_w_chans_o,
  output logic [NumMstPorts-1:0]                   mst_w_valids_o,
  input  logic [NumMstPorts-1:0]                   mst_w_readies_i,
  input  axi_chan_pkg::b_chan_t [NumMstPorts-1:0]  mst_b_chans_i,
  input  logic [NumMstPorts-1:0]                   mst_b_valids_i,
  output logic [NumMstPorts-1:0]                   mst_b_readies_o
);

  import demux_pkg::*;

  logic aw_push;
  sel_t lookup_sel;
  logic lookup_busy;
  logic cnt_full;
  logic fifo_full;
  logic fifo_empty;
  sel_t head_sel;
  logic w_pop;

  // --------------------
  // AW path
  // --------------------
  aw_issue #(
    .NumMstPorts (NumMstPorts)
  ) i_aw_issue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .slv_aw_chan_i    (slv_aw_chan_i),
    .slv_aw_sel_i     (slv_aw_sel_i),
    .slv_aw_valid_i   (slv_aw_valid_i),
    .slv_aw_ready_o   (slv_aw_ready_o),
    .mst_aw_chans_o   (mst_aw_chans_o),
    .mst_aw_valids_o  (mst_aw_valids_o),
    .mst_aw_readies_i (mst_aw_readies_i),
    .lookup_sel_i     (lookup_sel),
    .lookup_busy_i    (lookup_busy),
    .cnt_full_i       (cnt_full),
    .fifo_full_i      (fifo_full),
    .aw_push_o        (aw_push)
  );

  // Counters pop on every accepted B
  id_tracker #(
    .LookBits (LookBits),
    .CntWidth (CntWidth)
  ) i_id_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_id_i   (slv_aw_chan_i.id[LookBits-1:0]),
    .lookup_sel_o  (lookup_sel),
    .lookup_busy_o (lookup_busy),
    .full_o        (cnt_full),
    .push_i        (aw_push),
    .push_id_i     (slv_aw_chan_i.id[LookBits-1:0]),
    .push_sel_i    (slv_aw_sel_i),
    .pop_i         (slv_b_valid_o & slv_b_ready_i),
    .pop_id_i      (slv_b_chan_o.id[LookBits-1:0])
  );

  // --------------------
  // W path
  // --------------------
  sel_fifo #(
    .Depth (MaxTrans)
  ) i_sel_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (aw_push),
    .data_i  (slv_aw_sel_i),
    .pop_i   (w_pop),
    .data_o  (head_sel),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  w_steer #(
    .NumMstPorts (NumMstPorts)
  ) i_w_steer (
    .slv_w_chan_i    (slv_w_chan_i),
    .slv_w_valid_i   (slv_w_valid_i),
    .slv_w_ready_o   (slv_w_ready_o),
    .mst_w_chans_o   (mst_w_chans_o),
    .mst_w_valids_o  (mst_w_valids_o),
    .mst_w_readies_i (mst_w_readies_i),
    .empty_i         (fifo_empty),
    .head_sel_i      (head_sel),
    .pop_o           (w_pop)
  );

  // --------------------
  // B path
  // --------------------
  b_arbiter #(
    .NumMstPorts (NumMstPorts)
  ) i_b_arbiter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mst_b_chans_i   (mst_b_chans_i),
    .mst_b_valids_i  (mst_b_valids_i),
    .mst_b_readies_o (mst_b_readies_o),
    .slv_b_chan_o    (slv_b_chan_o),
    .slv_b_valid_o   (slv_b_valid_o),
    .slv_b_ready_i   (slv_b_ready_i)
  );

endmodule

// ==== tb/tb_axi_write_demux.sv ====
// Random-stimulus testbench for the write demultiplexer at default parameters.
// Port models accept AW and W at random and answer each burst with one B.
// Every master AW, W beat and slave B is checked against a model kept here.
// Inputs change on the rising edge, outputs are sampled on the falling edge.
// The run stops at the first mismatch.

`timescale 1ns/100ps

module tb_axi_write_demux;

  import axi_chan_pkg::*;
  import demux_pkg::*;

  localparam int unsigned NumPorts  = DefNumMstPorts;
  localparam int unsigned MaxTrans  = DefMaxTrans;
  localparam int          NumIds    = 2 ** DefLookBits;
  localparam int          NumBursts = 200;
  localparam int          ClkPeriod = 40;

  // AW beat together with its port select
  typedef struct packed {
    aw_chan_t aw;
    sel_t     sel;
  } burst_t;

  logic                    clk_i;
  logic                    rst_ni;
  aw_chan_t                slv_aw_chan_i;
  sel_t                    slv_aw_sel_i;
  logic                    slv_aw_valid_i;
  logic                    slv_aw_ready_o;
  w_chan_t                 slv_w_chan_i;
  logic                    slv_w_valid_i;
  logic                    slv_w_ready_o;
  b_chan_t                 slv_b_chan_o;
  logic                    slv_b_valid_o;
  logic                    slv_b_ready_i;
  aw_chan_t [NumPorts-1:0] mst_aw_chans_o;
  logic [NumPorts-1:0]     mst_aw_valids_o;
  logic [NumPorts-1:0]     mst_aw_readies_i;
  w_chan_t [NumPorts-1:0]  mst_w_chans_o;
  logic [NumPorts-1:0]     mst_w_valids_o;
  logic [NumPorts-1:0]     mst_w_readies_i;
  b_chan_t [NumPorts-1:0]  mst_b_chans_i;
  logic [NumPorts-1:0]     mst_b_valids_i;
  logic [NumPorts-1:0]     mst_b_readies_o;

  integer seed = 92693;

  // ------------------
  // Model state
  // ------------------
  burst_t  aw_exp [$];
  burst_t  w_pend [$];
  w_chan_t w_drive [$];
  w_chan_t w_exp [$];
  b_chan_t b_q [NumPorts][$];
  int      id_cnt [NumIds];
  sel_t    id_port [NumIds];
  int      issued;
  int      b_count;
  int      beat_cnt;
  logic    aw_fire;
  logic    w_fire;
  logic    b_stalled;
  b_chan_t b_held;

  axi_write_demux #(
    .NumMstPorts (NumPorts),
    .MaxTrans    (MaxTrans),
    .CntWidth    (DefCntWidth),
    .LookBits    (DefLookBits)
  ) dut0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .slv_aw_chan_i    (slv_aw_chan_i),
    .slv_aw_sel_i     (slv_aw_sel_i),
    .slv_aw_valid_i   (slv_aw_valid_i),
    .slv_aw_ready_o   (slv_aw_ready_o),
    .slv_w_chan_i     (slv_w_chan_i),
    .slv_w_valid_i    (slv_w_valid_i),
    .slv_w_ready_o    (slv_w_ready_o),
    .slv_b_chan_o     (slv_b_chan_o),
    .slv_b_valid_o    (slv_b_valid_o),
    .slv_b_ready_i    (slv_b_ready_i),
    .mst_aw_chans_o   (mst_aw_chans_o),
    .mst_aw_valids_o  (mst_aw_valids_o),
    .mst_aw_readies_i (mst_aw_readies_i),
    .mst_w_chans_o    (mst_w_chans_o),
    .mst_w_valids_o   (mst_w_valids_o),
    .mst_w_readies_i  (mst_w_readies_i),
    .mst_b_chans_i    (mst_b_chans_i),
    .mst_b_valids_i   (mst_b_valids_i),
    .mst_b_readies_o  (mst_b_readies_o)
  );

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  task automatic stop_failed();
    $display("Testbench failed");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic expect_equal(input string test, input logic [63:0] expected,
                              input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("** Error [%s] expected %0h, actual %0h", test, expected, actual);
      stop_failed();
    end
  endtask

  task automatic require(input string what, input logic cond);
    assert (cond) else begin
      $display("Check failed at %0t: %s", $time, what);
      stop_failed();
    end
  endtask

  task automatic quiet_outputs(input string phase);
    expect_equal({phase, " aw valids"}, 64'd0, 64'(mst_aw_valids_o));
    expect_equal({phase, " w valids"}, 64'd0, 64'(mst_w_valids_o));
    expect_equal({phase, " b valid"}, 64'd0, 64'(slv_b_valid_o));
    expect_equal({phase, " w ready"}, 64'd0, 64'(slv_w_ready_o));
    expect_equal({phase, " aw ready"}, 64'd0, 64'(slv_aw_ready_o));
  endtask

  function automatic logic drained();
    logic ok;
    ok = (issued == NumBursts) && (aw_exp.size() == 0) && (w_pend.size() == 0);
    ok = ok && (w_exp.size() == 0) && (w_drive.size() == 0);
    for (int p = 0; p < int'(NumPorts); p++) begin
      ok = ok && (b_q[p].size() == 0);
    end
    for (int i = 0; i < NumIds; i++) begin
      ok = ok && (id_cnt[i] == 0);
    end
    return ok;
  endfunction

  // --------------------
  // Stimulus
  // --------------------
  task automatic issue_aw();
    logic [31:0] r;
    burst_t      b;
    w_chan_t     w;
    if (!slv_aw_valid_i || aw_fire) begin
      r = next_rand();
      if (issued < NumBursts && r[1:0] != 2'b00) begin
        b.sel      = sel_t'(r[15:8] % NumPorts);
        b.aw.id    = id_t'(r[19:16]);
        b.aw.addr  = next_rand();
        b.aw.len   = 8'(r[21:20]);
        b.aw.size  = 3'd2;
        b.aw.burst = 2'b01;
        aw_exp.push_back(b);
        // W beats of this burst, streamed in AW order
        for (int k = 0; k <= int'(b.aw.len); k++) begin
          w.data = next_rand();
          w.strb = r[27:24];
          w.last = (k == int'(b.aw.len));
          w_drive.push_back(w);
          w_exp.push_back(w);
        end
        slv_aw_chan_i  <= b.aw;
        slv_aw_sel_i   <= b.sel;
        slv_aw_valid_i <= 1'b1;
        issued++;
      end else begin
        slv_aw_valid_i <= 1'b0;
      end
    end
  endtask

  task automatic stream_w();
    logic [31:0] r;
    if (!slv_w_valid_i || w_fire) begin
      r = next_rand();
      if (w_drive.size() > 0 && r[1:0] != 2'b00) begin
        slv_w_chan_i  <= w_drive.pop_front();
        slv_w_valid_i <= 1'b1;
      end else begin
        slv_w_valid_i <= 1'b0;
      end
    end
  endtask

  // Port models offer their oldest queued B
  task automatic present_b();
    for (int p = 0; p < int'(NumPorts); p++) begin
      if (b_q[p].size() > 0) begin
        mst_b_valids_i[p] <= 1'b1;
        mst_b_chans_i[p]  <= b_q[p][0];
      end else begin
        mst_b_valids_i[p] <= 1'b0;
      end
    end
  endtask

  always @(posedge clk_i) begin : drive
    if (rst_ni) begin
      issue_aw();
      stream_w();
      present_b();
      mst_aw_readies_i <= NumPorts'(next_rand());
      mst_w_readies_i  <= NumPorts'(next_rand());
      slv_b_ready_i    <= ^next_rand();
    end
  end

  // --------------------
  // Monitors
  // --------------------
  task automatic track_w();
    logic [NumPorts-1:0] mst_fire;
    w_chan_t             exp_w;
    w_chan_t             act_w;
    b_chan_t             rsp;
    logic [31:0]         r;
    mst_fire = mst_w_valids_o & mst_w_readies_i;
    w_fire   = slv_w_valid_i && slv_w_ready_o;
    require("more than one master W valid", $onehot0(mst_w_valids_o));
    expect_equal("w handshake", 64'(w_fire), 64'(mst_fire != '0));
    if (mst_w_valids_o != '0) begin
      require("W valid with no burst waiting for data", w_pend.size() > 0);
    end
    if (mst_w_valids_o != '0 && w_pend.size() > 0) begin
      expect_equal("w port", 64'(NumPorts'(1) << w_pend[0].sel), 64'(mst_w_valids_o));
    end
    if (w_fire && w_pend.size() > 0) begin
      exp_w = w_exp.pop_front();
      act_w = mst_w_chans_o[w_pend[0].sel];
      beat_cnt++;
      // Burst ends on the port where the last bit shows up
      if (act_w.last) begin
        expect_equal("w beat count", 64'(w_pend[0].aw.len) + 64'd1, 64'(beat_cnt));
      end
      expect_equal("w payload", 64'(exp_w), 64'(act_w));
      if (exp_w.last) begin
        // Port model answers after the last beat
        r        = next_rand();
        rsp.id   = w_pend[0].aw.id;
        rsp.resp = r[1:0];
        b_q[w_pend[0].sel].push_back(rsp);
        void'(w_pend.pop_front());
        beat_cnt = 0;
      end
    end
  endtask

  task automatic sample_aw();
    burst_t exp_b;
    int     idx;
    aw_fire = slv_aw_valid_i && slv_aw_ready_o;
    require("more than one master AW valid", $onehot0(mst_aw_valids_o));
    expect_equal("aw handshake", 64'(aw_fire),
                 64'((mst_aw_valids_o & mst_aw_readies_i) != '0));
    if (aw_fire) begin
      exp_b = aw_exp.pop_front();
      idx   = int'(exp_b.aw.id[DefLookBits-1:0]);
      expect_equal("aw port", 64'(NumPorts'(1) << exp_b.sel), 64'(mst_aw_valids_o));
      expect_equal("aw payload", 64'(exp_b.aw), 64'(mst_aw_chans_o[exp_b.sel]));
      if (id_cnt[idx] != 0) begin
        expect_equal("aw same id port", 64'(id_port[idx]), 64'(exp_b.sel));
      end
      id_cnt[idx]++;
      id_port[idx] = exp_b.sel;
      w_pend.push_back(exp_b);
      require("more bursts waiting for W data than MaxTrans", w_pend.size() <= MaxTrans);
    end
  endtask

  task automatic collect_b();
    b_chan_t rsp;
    int      port;
    int      idx;
    logic    fire;
    fire = slv_b_valid_o && slv_b_ready_i;
    if (b_stalled) begin
      require("slave B valid dropped before it was accepted", slv_b_valid_o);
      expect_equal("b stalled payload", 64'(b_held), 64'(slv_b_chan_o));
    end
    b_stalled = slv_b_valid_o && !slv_b_ready_i;
    b_held    = slv_b_chan_o;
    require("more than one master B ready", $onehot0(mst_b_readies_o));
    expect_equal("b handshake", 64'(fire), 64'((mst_b_readies_o & mst_b_valids_i) != '0));
    if (fire) begin
      port = 0;
      for (int p = 0; p < int'(NumPorts); p++) begin
        if (mst_b_readies_o[p]) begin
          port = p;
        end
      end
      require("B taken from a port with no response queued", b_q[port].size() > 0);
      rsp = b_q[port].pop_front();
      expect_equal("b payload", 64'(rsp), 64'(slv_b_chan_o));
      idx = int'(rsp.id[DefLookBits-1:0]);
      id_cnt[idx]--;
      b_count++;
    end
  endtask

  // W first, so a burst pushed this cycle is never matched against a beat
  always @(negedge clk_i) begin : monitor
    if (rst_ni) begin
      track_w();
      sample_aw();
      collect_b();
    end
  end

  initial begin : watchdog
    #(NumBursts * 60 * ClkPeriod);
    $display("Timeout: only %0d of %0d responses returned", b_count, NumBursts);
    stop_failed();
  end

  initial begin : main
    rst_ni           = 1'b0;
    slv_aw_chan_i    = '0;
    slv_aw_sel_i     = '0;
    slv_aw_valid_i   = 1'b0;
    slv_w_chan_i     = '0;
    slv_w_valid_i    = 1'b0;
    slv_b_ready_i    = 1'b0;
    mst_aw_readies_i = '0;
    mst_w_readies_i  = '0;
    mst_b_chans_i    = '0;
    mst_b_valids_i   = '0;
    issued           = 0;
    b_count          = 0;
    beat_cnt         = 0;
    aw_fire          = 1'b0;
    w_fire           = 1'b0;
    b_stalled        = 1'b0;
    b_held           = '0;
    for (int i = 0; i < NumIds; i++) begin
      id_cnt[i]  = 0;
      id_port[i] = '0;
    end
    repeat (8) begin
      @(negedge clk_i);
      quiet_outputs("reset");
      @(posedge clk_i);
    end
    rst_ni <= 1'b1;
    @(negedge clk_i);
    quiet_outputs("after reset");
    wait (b_count == NumBursts);
    repeat (4) @(posedge clk_i);
    if (drained()) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Check failed: model still holds bursts after all responses returned");
      stop_failed();
    end
  end

endmodule

// ==== flist.f ====
common/axi_chan_pkg.sv
common/demux_pkg.sv
hdl/id_tracker.sv
hdl/sel_fifo.sv
axi_write_demux/aw_issue.sv
axi_write_demux/w_steer.sv
axi_write_demux/b_arbiter.sv
axi_write_demux/axi_write_demux.sv
tb/tb_axi_write_demux.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the write demultiplexer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module tb_axi_write_demux \
  -f flist.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Testbench passed" sim.log; then
  echo "Simulation result: PASS"
else
  echo "Simulation result: FAIL"
  exit 1
fi
